//--- include/retire_macros.svh
`ifndef RETIRE_MACROS_SVH
`define RETIRE_MACROS_SVH

// Retire width, how many ROB head entries may commit in one cycle
`define N_WAY 2

`define ARCH_REGS 16 // Architectural registers seen by software
`define PHYS_REGS 32 // Physical registers behind the rename map
`define ROB_DEPTH 8  // Reorder buffer slots

// Index widths derived from the sizes above
`define TAG_W 5     // Physical tag, log2 of PHYS_REGS
`define AREG_W 4    // Architectural index, log2 of ARCH_REGS
`define ROB_PTR_W 3 // ROB pointer, log2 of ROB_DEPTH
`define CNT_W 2     // Retire count, holds 0 to N_WAY

`define DATA_W 32 // Register value width

`endif

//--- verilog/retire_pkg.sv
`include "retire_macros.svh"

package retire_pkg;

    // Index and value types shared by every block of the commit end
    typedef logic [`TAG_W-1:0]  phys_tag_t;
    typedef logic [`AREG_W-1:0] arch_reg_t;
    typedef logic [`DATA_W-1:0] data_t;
    typedef logic [31:0]        addr_t; // Next PC carried to commit

    // One ROB slot as written at dispatch
    typedef struct packed {
        phys_tag_t t_new;    // Tag allocated for the destination
        phys_tag_t t_old;    // Previous mapping of arch_reg, freed at commit
        arch_reg_t arch_reg; // Architectural destination
        logic      has_dest; // Clear for stores, branches and the like
        logic      halt;     // Stops retirement once it commits
        logic      illegal;  // Passed through to the commit record
        addr_t     npc;
    } rob_entry_t;

    // What the core reports for each committed instruction
    typedef struct packed {
        logic      valid;
        arch_reg_t arch_reg;
        phys_tag_t phys_reg; // Tag that holds the committed value
        data_t     data;
        addr_t     npc;
        logic      halt;
        logic      illegal;
    } commit_packet_t;

    // Retirement runs until a halt commits, then sits until reset
    typedef enum logic {
        RETIRE_RUN,
        RETIRE_HALTED
    } retire_state_t;

endpackage

//--- verilog/rob_head_if.sv
`timescale 1ns/1ps
`include "retire_macros.svh"

// Head window of the ROB as seen by the retire logic
interface rob_head_if
    import retire_pkg::*;
();

    // Oldest entries first, slot 0 is the ROB head
    rob_entry_t [`N_WAY-1:0] head_entries;

    logic [`CNT_W-1:0] head_count;   // Valid entries in the window, at most N_WAY
    logic [`CNT_W-1:0] retire_count; // Entries popped at the coming edge

    // The ROB owns the window and follows the pop request
    modport rob (
        output head_entries,
        output head_count,
        input  retire_count
    );

    // The retire unit reads the window and decides how many leave
    modport retire (
        input  head_entries,
        input  head_count,
        output retire_count
    );

endinterface

//--- verilog/rob.sv
`timescale 1ns/1ps
`include "retire_macros.svh"

module rob
    import retire_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       dispatch_valid,
    input  rob_entry_t dispatch_entry,
    input  logic       dispatch_fire, // Valid and ready met at this edge
    output logic       full,
    rob_head_if.rob    head
);

    localparam int PTR_W = `ROB_PTR_W;
    localparam int OCC_W = `ROB_PTR_W + 1; // Occupancy needs to reach ROB_DEPTH
    localparam int CNT_W = `CNT_W;

    rob_entry_t entries [`ROB_DEPTH]; // Slot storage, contents only matter while occupied

    logic [PTR_W-1:0] head_ptr; // Oldest entry
    logic [PTR_W-1:0] tail_ptr; // Next slot to write
    logic [OCC_W-1:0] count;
    logic             push;

    // Fire is qualified by valid again so a stray fire never writes a bubble
    assign push = dispatch_fire && dispatch_valid;

    assign full = (count == OCC_W'(`ROB_DEPTH));

    // Present the oldest N_WAY slots, pointers wrap naturally at ROB_DEPTH
    always_comb begin
        for (int i = 0; i < `N_WAY; i++) begin
            head.head_entries[i] = entries[head_ptr + PTR_W'(i)];
        end
        if (count >= OCC_W'(`N_WAY)) begin
            head.head_count = CNT_W'(`N_WAY); // Window is full
        end else begin
            head.head_count = CNT_W'(count); // Fewer entries than retire slots
        end
    end

    // Payload write at the tail slot
    always_ff @(posedge clock) begin
        if (push) begin
            entries[tail_ptr] <= dispatch_entry;
        end
    end

    // Pointer and occupancy update, a push and a pop can share one edge
    always_ff @(posedge clock) begin
        if (reset) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (push) begin
                tail_ptr <= tail_ptr + PTR_W'(1);
            end
            head_ptr <= head_ptr + PTR_W'(head.retire_count); // Oldest entries leave first
            count    <= count + OCC_W'(push) - OCC_W'(head.retire_count);
        end
    end

endmodule

//--- verilog/free_list.sv
`timescale 1ns/1ps
`include "retire_macros.svh"

module free_list
    import retire_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    pop,        // Dispatch takes the head tag
    output phys_tag_t               head_tag,
    output logic                    empty,
    input  phys_tag_t [`N_WAY-1:0]  free_tags,  // Slot 0 is pushed first
    input  logic [`CNT_W-1:0]       free_count  // Number of free_tags entries in use
);

    localparam int PTR_W = `TAG_W;     // Depth equals PHYS_REGS so a tag-wide pointer wraps
    localparam int OCC_W = `TAG_W + 1; // Occupancy can reach PHYS_REGS

    phys_tag_t        mem [`PHYS_REGS];
    logic [PTR_W-1:0] head_ptr;
    logic [PTR_W-1:0] tail_ptr;
    logic [OCC_W-1:0] count;
    logic             do_pop;

    assign empty    = (count == '0);
    assign head_tag = mem[head_ptr]; // Visible in the same cycle as dispatch
    assign do_pop   = pop && !empty;

    // Reset loads the FIFO with the tags that start out unmapped
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `PHYS_REGS; i++) begin
                // Slots 0 to 15 get tags 16 to 31, the upper half wraps and is not yet valid
                mem[i] <= PTR_W'(i + `ARCH_REGS);
            end
            head_ptr <= '0;
            tail_ptr <= PTR_W'(`PHYS_REGS - `ARCH_REGS);
            count    <= OCC_W'(`PHYS_REGS - `ARCH_REGS);
        end else begin
            // Freed tags go in behind the last valid slot in commit order
            for (int i = 0; i < `N_WAY; i++) begin
                if (i < free_count) begin
                    mem[tail_ptr + PTR_W'(i)] <= free_tags[i];
                end
            end
            tail_ptr <= tail_ptr + PTR_W'(free_count);
            if (do_pop) begin
                head_ptr <= head_ptr + PTR_W'(1);
            end
            // Only 32 tags exist, so pushes never overrun the FIFO
            count <= count + OCC_W'(free_count) - OCC_W'(do_pop);
        end
    end

endmodule

//--- verilog/phys_regfile.sv
`timescale 1ns/1ps
`include "retire_macros.svh"

module phys_regfile
    import retire_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    complete_valid,
    input  phys_tag_t               complete_tag,
    input  data_t                   complete_data,
    input  logic                    alloc_valid,   // Dispatch allocates alloc_tag
    input  phys_tag_t               alloc_tag,
    input  phys_tag_t [`N_WAY-1:0]  read_tags,
    output data_t [`N_WAY-1:0]      read_data,
    output logic [`PHYS_REGS-1:0]   complete_bits
);

    data_t regs [`PHYS_REGS];

    // Retire read ports are plain muxes, data written at an edge is seen right after it
    always_comb begin
        for (int i = 0; i < `N_WAY; i++) begin
            read_data[i] = regs[read_tags[i]];
        end
    end

    // Tags 0 to 15 start as the committed state of arch regs 0 to 15, all zero
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `PHYS_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (complete_valid) begin
            regs[complete_tag] <= complete_data;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            complete_bits <= {{(`PHYS_REGS - `ARCH_REGS){1'b0}}, {`ARCH_REGS{1'b1}}};
        end else begin
            // A fresh allocation is busy until its producer completes
            if (alloc_valid) begin
                complete_bits[alloc_tag] <= 1'b0;
            end
            // Completion is applied last, a free tag is never allocated and completed together
            if (complete_valid) begin
                complete_bits[complete_tag] <= 1'b1;
            end
        end
    end

endmodule

//--- verilog/retire_unit.sv
`timescale 1ns/1ps
`include "retire_macros.svh"

module retire_unit
    import retire_pkg::*;
(
    input  logic                        clock,
    input  logic                        reset,
    rob_head_if.retire                  head,
    input  logic [`PHYS_REGS-1:0]       complete_bits,
    output phys_tag_t [`N_WAY-1:0]      read_tags,
    input  data_t [`N_WAY-1:0]          read_data,
    output phys_tag_t [`N_WAY-1:0]      free_tags,   // Packed from slot 0 upward
    output logic [`CNT_W-1:0]           free_count,
    output commit_packet_t [`N_WAY-1:0] commit,
    output logic                        halted
);

    retire_state_t state;
    retire_state_t next_state;
    logic          stop; // Set once a slot fails or a halt has gone by

    assign halted = (state == RETIRE_HALTED);

    always_comb begin
        head.retire_count = '0;
        free_tags         = '0;
        free_count        = '0;
        commit            = '0;
        next_state        = state;
        stop              = (state == RETIRE_HALTED); // Nothing leaves once halted
        for (int i = 0; i < `N_WAY; i++) begin
            read_tags[i] = head.head_entries[i].t_new; // Read every slot, only committed ones are used
            if (!stop && (i < head.head_count) && complete_bits[head.head_entries[i].t_new]) begin
                commit[i].valid    = 1'b1;
                commit[i].arch_reg = head.head_entries[i].arch_reg;
                commit[i].phys_reg = head.head_entries[i].t_new;
                commit[i].data     = read_data[i];
                commit[i].npc      = head.head_entries[i].npc;
                commit[i].halt     = head.head_entries[i].halt;
                commit[i].illegal  = head.head_entries[i].illegal;
                // The old mapping is dead now, an entry with no destination returns its own tag
                free_tags[free_count] = head.head_entries[i].has_dest ?
                                        head.head_entries[i].t_old : head.head_entries[i].t_new;
                free_count        = free_count + 1'b1;
                head.retire_count = head.retire_count + 1'b1;
                if (head.head_entries[i].halt) begin
                    stop       = 1'b1; // Younger slots must not pass the halt
                    next_state = RETIRE_HALTED;
                end
            end else begin
                stop = 1'b1; // In-order commit, the first blocked slot blocks the rest
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= RETIRE_RUN;
        end else begin
            state <= next_state;
        end
    end

endmodule

//--- verilog/commit_top.sv
`timescale 1ns/1ps
`include "retire_macros.svh"

module commit_top
    import retire_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset,
    // Dispatch from rename, valid/ready handshake
    input  logic                   dispatch_valid,
    input  arch_reg_t              dispatch_arch_reg,
    input  phys_tag_t              dispatch_t_old,
    input  logic                   dispatch_has_dest,
    input  logic                   dispatch_halt,
    input  logic                   dispatch_illegal,
    input  addr_t                  dispatch_npc,
    output logic                   dispatch_ready,
    output phys_tag_t              dispatch_tag,
    // Completion from execute, always accepted
    input  logic                   complete_valid,
    input  phys_tag_t              complete_tag,
    input  data_t                  complete_data,
    // Commit, one set per slot
    output logic [`N_WAY-1:0]      commit_valid,
    output arch_reg_t [`N_WAY-1:0] commit_arch_reg,
    output phys_tag_t [`N_WAY-1:0] commit_phys_reg,
    output data_t [`N_WAY-1:0]     commit_data,
    output addr_t [`N_WAY-1:0]     commit_npc,
    output logic [`N_WAY-1:0]      commit_halt,
    output logic [`N_WAY-1:0]      commit_illegal,
    output logic                   halted
);

    rob_head_if head_if ();

    logic                        rob_full;
    logic                        fl_empty;
    logic                        dispatch_fire;
    rob_entry_t                  dispatch_entry;
    logic [`PHYS_REGS-1:0]       complete_bits;
    phys_tag_t [`N_WAY-1:0]      read_tags;
    data_t [`N_WAY-1:0]          read_data;
    phys_tag_t [`N_WAY-1:0]      free_tags;
    logic [`CNT_W-1:0]           free_count;
    commit_packet_t [`N_WAY-1:0] commit;

    // Needs a ROB slot and a free tag, and nothing is accepted after a halt
    assign dispatch_ready = !rob_full && !fl_empty && !halted;
    assign dispatch_fire  = dispatch_valid && dispatch_ready;

    always_comb begin
        dispatch_entry          = '0;
        dispatch_entry.t_new    = dispatch_tag; // The free-list head becomes the new mapping
        dispatch_entry.t_old    = dispatch_t_old;
        dispatch_entry.arch_reg = dispatch_arch_reg;
        dispatch_entry.has_dest = dispatch_has_dest;
        dispatch_entry.halt     = dispatch_halt;
        dispatch_entry.illegal  = dispatch_illegal;
        dispatch_entry.npc      = dispatch_npc;
    end

    rob u_rob (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_entry (dispatch_entry),
        .dispatch_fire  (dispatch_fire),
        .full           (rob_full),
        .head           (head_if.rob)
    );

    free_list u_free_list (
        .clock      (clock),
        .reset      (reset),
        .pop        (dispatch_fire),
        .head_tag   (dispatch_tag),
        .empty      (fl_empty),
        .free_tags  (free_tags),
        .free_count (free_count)
    );

    phys_regfile u_phys_regfile (
        .clock          (clock),
        .reset          (reset),
        .complete_valid (complete_valid),
        .complete_tag   (complete_tag),
        .complete_data  (complete_data),
        .alloc_valid    (dispatch_fire),
        .alloc_tag      (dispatch_tag),
        .read_tags      (read_tags),
        .read_data      (read_data),
        .complete_bits  (complete_bits)
    );

    retire_unit u_retire_unit (
        .clock         (clock),
        .reset         (reset),
        .head          (head_if.retire),
        .complete_bits (complete_bits),
        .read_tags     (read_tags),
        .read_data     (read_data),
        .free_tags     (free_tags),
        .free_count    (free_count),
        .commit        (commit),
        .halted        (halted)
    );

    // Spread the commit records onto the flat per-slot ports
    always_comb begin
        for (int i = 0; i < `N_WAY; i++) begin
            commit_valid[i]    = commit[i].valid;
            commit_arch_reg[i] = commit[i].arch_reg;
            commit_phys_reg[i] = commit[i].phys_reg;
            commit_data[i]     = commit[i].data;
            commit_npc[i]      = commit[i].npc;
            commit_halt[i]     = commit[i].halt;
            commit_illegal[i]  = commit[i].illegal;
        end
    end

endmodule

//--- bench/commit_props.sv
`timescale 1ns/1ps
`include "retire_macros.svh"

// Protocol rules of the commit end, attached to every commit_top below
module commit_props (
    input logic              clock,
    input logic              reset,
    input logic              dispatch_valid,
    input logic [`N_WAY-1:0] commit_valid,
    input logic              halted,
    input logic              dispatch_ready
);

    localparam int OCC_W = `ROB_PTR_W + 1; // Occupancy reaches ROB_DEPTH

    int assert_failures = 0; // Failed assertions so far

    logic [OCC_W-1:0] occupancy; // ROB entries in flight, rebuilt from the top-level ports

    always_ff @(posedge clock) begin
        if (reset) begin
            occupancy <= '0;
        end else begin
            // Each transfer adds an entry and each valid commit slot removes one
            occupancy <= occupancy + OCC_W'(dispatch_valid && dispatch_ready)
                         - OCC_W'($countones(commit_valid));
        end
    end

    // Commits fill the slots from slot 0 upward
    slot_order: assert property (@(posedge clock) disable iff (reset)
        commit_valid[1] |-> commit_valid[0])
        else begin
            $error("commit slot 1 is valid while slot 0 is not");
            assert_failures = assert_failures + 1;
        end

    no_commit_halted: assert property (@(posedge clock) disable iff (reset)
        halted |-> (commit_valid == '0)) // Retirement is frozen after a halt
        else begin
            $error("an entry committed while halted");
            assert_failures = assert_failures + 1;
        end

    // A ROB holding ROB_DEPTH entries must hold off dispatch
    full_blocks_dispatch: assert property (@(posedge clock) disable iff (reset)
        (occupancy == OCC_W'(`ROB_DEPTH)) |-> !dispatch_ready)
        else begin
            $error("dispatch_ready is high with the ROB full");
            assert_failures = assert_failures + 1;
        end

    // Only a reset may clear the halted state
    halt_sticky: assert property (@(posedge clock) disable iff (reset)
        $fell(halted) |-> $past(reset))
        else begin
            $error("halted fell without a reset");
            assert_failures = assert_failures + 1;
        end

endmodule

bind commit_top commit_props props_i (
    .clock          (clock),
    .reset          (reset),
    .dispatch_valid (dispatch_valid),
    .commit_valid   (commit_valid),
    .halted         (halted),
    .dispatch_ready (dispatch_ready)
);

//--- bench/commit_tb.sv
`timescale 1ns/1ps
`include "retire_macros.svh"

module commit_tb
    import retire_pkg::*;
();

    localparam int NUM_TESTS       = 5;
    localparam int CYCLES_PER_TEST = 200; // Watchdog budget for one directed test

    logic                   clock;
    logic                   reset;
    logic                   dispatch_valid, dispatch_has_dest, dispatch_halt, dispatch_illegal;
    arch_reg_t              dispatch_arch_reg;
    phys_tag_t              dispatch_t_old, dispatch_tag, complete_tag;
    addr_t                  dispatch_npc;
    logic                   dispatch_ready, complete_valid, halted;
    data_t                  complete_data;
    logic [`N_WAY-1:0]      commit_valid, commit_halt, commit_illegal;
    arch_reg_t [`N_WAY-1:0] commit_arch_reg;
    phys_tag_t [`N_WAY-1:0] commit_phys_reg;
    data_t [`N_WAY-1:0]     commit_data;
    addr_t [`N_WAY-1:0]     commit_npc;

    rob_entry_t rob_q [$];                // Model ROB, oldest entry at index 0
    phys_tag_t  fl_q [$];                 // Model free list in FIFO order
    phys_tag_t  map_table [`ARCH_REGS];   // Current mapping, supplies T_old
    data_t      regdata [`PHYS_REGS];     // Last completed value of every tag
    addr_t      pc;
    integer     seed;
    string      test_name;

    commit_top dut_i (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic report_error(input string msg);
        $display("ERROR in %s: %s", test_name, msg);
        $display("TB FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_commit(input commit_packet_t exp, input commit_packet_t act,
                                input string what);
        if (exp !== act) begin
            $display("MISMATCH %s %s expected %h actual %h", test_name, what, exp, act);
            report_error("commit record differs");
        end
    endtask

    task automatic check_tag(input phys_tag_t exp, input phys_tag_t act, input string what);
        if (exp !== act) begin
            $display("MISMATCH %s %s expected %0d actual %0d", test_name, what, exp, act);
            report_error("physical tag differs");
        end
    endtask

    task automatic check_flag(input logic exp, input logic act, input string what);
        if (exp !== act) begin
            $display("MISMATCH %s %s expected %b actual %b", test_name, what, exp, act);
            report_error("status flag differs");
        end
    endtask

    // One dispatch handshake; the tag offered must be the model free-list head
    task automatic dispatch_inst(input arch_reg_t arch, input logic has_dest, input logic halt,
                                 input logic illegal, output phys_tag_t tag);
        rob_entry_t entry;
        entry          = '0;
        pc             = pc + 32'd4;
        entry.t_new    = fl_q[0];
        entry.t_old    = has_dest ? map_table[arch] : entry.t_new; // Unused without a dest
        entry.arch_reg = arch;
        entry.has_dest = has_dest;
        entry.halt     = halt;
        entry.illegal  = illegal;
        entry.npc      = pc;
        @(posedge clock);
        dispatch_valid    <= 1'b1;
        dispatch_arch_reg <= arch;
        dispatch_t_old    <= entry.t_old;
        dispatch_has_dest <= has_dest;
        dispatch_halt     <= halt;
        dispatch_illegal  <= illegal;
        dispatch_npc      <= pc;
        @(negedge clock);
        check_flag(1'b1, dispatch_ready, "dispatch_ready");
        check_tag(entry.t_new, dispatch_tag, "dispatch_tag");
        @(posedge clock); // Transfer edge
        dispatch_valid <= 1'b0;
        tag = fl_q.pop_front();
        if (has_dest) map_table[arch] = tag;
        rob_q.push_back(entry);
    endtask

    task automatic send_completion(input phys_tag_t tag, input data_t value);
        @(posedge clock);
        complete_valid <= 1'b1;
        complete_tag   <= tag;
        complete_data  <= value;
        @(posedge clock); // Data and complete bit are written here
        complete_valid <= 1'b0;
        regdata[tag] = value;
    endtask

    // Checks both slots in the coming cycle, then retires n entries from the models
    task automatic expect_commits(input int n);
        commit_packet_t exp_pkt, act_pkt;
        rob_entry_t     entry;
        @(negedge clock);
        for (int i = 0; i < `N_WAY; i++) begin
            exp_pkt = '0; // Idle slots drive all zeros
            if (i < n) begin
                entry            = rob_q[i];
                exp_pkt.valid    = 1'b1;
                exp_pkt.arch_reg = entry.arch_reg;
                exp_pkt.phys_reg = entry.t_new;
                exp_pkt.data     = regdata[entry.t_new];
                exp_pkt.npc      = entry.npc;
                exp_pkt.halt     = entry.halt;
                exp_pkt.illegal  = entry.illegal;
            end
            act_pkt = {commit_valid[i], commit_arch_reg[i], commit_phys_reg[i], commit_data[i],
                       commit_npc[i], commit_halt[i], commit_illegal[i]};
            check_commit(exp_pkt, act_pkt, $sformatf("slot %0d", i));
        end
        for (int i = 0; i < n; i++) begin
            entry = rob_q.pop_front();
            fl_q.push_back(entry.has_dest ? entry.t_old : entry.t_new); // Slot order
        end
    endtask

    task automatic single_commit();
        phys_tag_t tag;
        test_name = "single_commit";
        expect_commits(0); // Nothing in flight right after reset
        check_flag(1'b0, halted, "halted");
        check_flag(1'b1, dispatch_ready, "dispatch_ready");
        dispatch_inst(4'd1, 1'b1, 1'b0, 1'b0, tag);
        send_completion(tag, $random(seed));
        expect_commits(1);
    endtask

    task automatic out_of_order_completion();
        phys_tag_t older, younger;
        test_name = "out_of_order_completion";
        dispatch_inst(4'd2, 1'b1, 1'b0, 1'b0, older);
        dispatch_inst(4'd3, 1'b1, 1'b0, 1'b1, younger);
        send_completion(younger, $random(seed));
        expect_commits(0); // Younger waits behind the head
        send_completion(older, $random(seed));
        expect_commits(2);
    endtask

    // Runs the free list past its initial tags so recycled ones come back out
    task automatic free_list_recycling();
        phys_tag_t tag;
        test_name = "free_list_recycling";
        for (int i = 0; i < 20; i++) begin
            dispatch_inst(arch_reg_t'(i), (i % 3) != 2, 1'b0, (i % 5) == 4, tag);
            send_completion(tag, $random(seed));
            expect_commits(1);
        end
    endtask

    task automatic back_pressure();
        phys_tag_t tag;
        test_name = "back_pressure";
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            dispatch_inst(arch_reg_t'(i + 4), 1'b1, 1'b0, 1'b0, tag);
        end
        @(negedge clock);
        check_flag(1'b0, dispatch_ready, "dispatch_ready when full");
        send_completion(rob_q[0].t_new, $random(seed));
        expect_commits(1);
        @(negedge clock);
        check_flag(1'b1, dispatch_ready, "dispatch_ready after one retire");
        for (int i = `ROB_DEPTH - 2; i > 0; i--) begin
            send_completion(rob_q[i].t_new, $random(seed)); // Youngest first
            expect_commits(0);
        end
        send_completion(rob_q[0].t_new, $random(seed));
        expect_commits(2); // The whole backlog drains two per cycle
        expect_commits(2);
        expect_commits(2);
        expect_commits(1);
    endtask

    task automatic halt_stops_retire();
        phys_tag_t halt_tag, tag_a, tag_b;
        test_name = "halt_stops_retire";
        dispatch_inst(4'd9, 1'b1, 1'b1, 1'b0, halt_tag);
        dispatch_inst(4'd10, 1'b1, 1'b0, 1'b0, tag_a);
        dispatch_inst(4'd11, 1'b0, 1'b0, 1'b0, tag_b);
        send_completion(tag_a, $random(seed));
        expect_commits(0);
        send_completion(tag_b, $random(seed));
        expect_commits(0);
        send_completion(halt_tag, $random(seed));
        expect_commits(1); // Slot 1 is complete but must not pass the halt
        @(negedge clock);
        check_flag(1'b1, halted, "halted");
        check_flag(1'b0, dispatch_ready, "dispatch_ready after halt");
        repeat (4) expect_commits(0);
    endtask

    initial begin
        repeat (NUM_TESTS * CYCLES_PER_TEST + 10) @(posedge clock);
        report_error("timeout, the directed tests did not finish in their cycle budget");
    end

    // A failing bound assertion ends the run at once
    always @(dut_i.props_i.assert_failures) begin
        if (dut_i.props_i.assert_failures != 0) begin
            report_error("a bound assertion failed");
        end
    end

    initial begin
        seed              = 7172;
        pc                = 32'h0000_1000;
        reset             <= 1'b1;
        dispatch_valid    <= 1'b0;
        dispatch_arch_reg <= '0;
        dispatch_t_old    <= '0;
        dispatch_has_dest <= 1'b0;
        dispatch_halt     <= 1'b0;
        dispatch_illegal  <= 1'b0;
        dispatch_npc      <= '0;
        complete_valid    <= 1'b0;
        complete_tag      <= '0;
        complete_data     <= '0;
        for (int i = 0; i < `ARCH_REGS; i++) map_table[i] = phys_tag_t'(i); // Identity map
        for (int i = 0; i < `PHYS_REGS; i++) regdata[i] = '0;
        for (int i = `ARCH_REGS; i < `PHYS_REGS; i++) fl_q.push_back(phys_tag_t'(i));
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        single_commit();
        out_of_order_completion();
        free_list_recycling();
        back_pressure();
        halt_stops_retire();
        repeat (2) @(posedge clock); // Let the bound assertions see the last cycles
        test_name = "end_of_run";
        if (dut_i.props_i.assert_failures == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            report_error("a bound assertion failed during the run");
        end
    end

endmodule

//--- src.f
+incdir+include
verilog/retire_pkg.sv
verilog/rob_head_if.sv
verilog/rob.sv
verilog/free_list.sv
verilog/phys_regfile.sv
verilog/retire_unit.sv
verilog/commit_top.sv
bench/commit_props.sv
bench/commit_tb.sv

//--- Bender.yml
package:
  name: commit_end

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/retire_pkg.sv
      - verilog/rob_head_if.sv
      - verilog/rob.sv
      - verilog/free_list.sv
      - verilog/phys_regfile.sv
      - verilog/retire_unit.sv
      - verilog/commit_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/commit_props.sv
      - bench/commit_tb.sv
